/* mul_cfg_pkg.sv */
package mul_cfg_pkg;

    ////////////////////////////////////////
    // Datapath widths

    // One register operand
    localparam int DATA_WIDTH     = 32;

    // Full unsigned product of two operands
    localparam int PRODUCT_WIDTH  = 2 * DATA_WIDTH;

    ////////////////////////////////////////
    // Core bookkeeping widths

    // Reorder buffer ticket
    localparam int ROB_ID_WIDTH   = 5;

    // Architectural register address
    localparam int REG_ADDR_WIDTH = 5;

    localparam int PC_WIDTH       = 32;

    ////////////////////////////////////////
    // Multiplier timing

    // Register stages between issue and the writeback register
    localparam int MUL_STAGES     = 3;

endpackage

/* mul_types_pkg.sv */
package mul_types_pkg;

    import mul_cfg_pkg::*;

    ////////////////////////////////////////
    // Decode to multiply unit

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     ra_data;
        logic [DATA_WIDTH-1:0]     rb_data;
        // Renamed sources in the ROB
        logic [ROB_ID_WIDTH-1:0]   ticket_src1;
        logic [ROB_ID_WIDTH-1:0]   ticket_src2;
        // Source value still owned by an older instruction
        logic                      rob_blocks_src1;
        logic                      rob_blocks_src2;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [ROB_ID_WIDTH-1:0]   instr_id;
        logic [PC_WIDTH-1:0]       pc;
    } mul_request_t;

    ////////////////////////////////////////
    // Carried beside the product

    typedef struct packed {
        logic [ROB_ID_WIDTH-1:0]   instr_id;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [PC_WIDTH-1:0]       pc;
    } mul_tag_t;

    ////////////////////////////////////////
    // Multiply unit to writeback

    typedef struct packed {
        logic [ROB_ID_WIDTH-1:0]   instr_id;
        logic [PC_WIDTH-1:0]       pc;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        // Low half of the product
        logic [DATA_WIDTH-1:0]     data;
        // High half nonzero
        logic                      overflow;
    } wb_request_t;

endpackage

/* delay_line.sv */
module delay_line
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
)
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] valid_q;
    payload_t         data_q [DEPTH];

    // Valid chain
    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
            valid_q <= '0;
        else
        begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    // Payload only moves with a valid entry
    always_ff @(posedge clock)
    begin
        if (in_valid)
            data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++)
            if (valid_q[i-1])
                data_q[i] <= data_q[i-1];
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

/* operand_collector.sv */
module operand_collector
(
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 flush,

    // Request from decode
    input  logic                                 req_valid,
    input  mul_types_pkg::mul_request_t          req_info,
    output logic                                 stall,

    // ROB lookup, answered in the same cycle
    output logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rob_src1_id,
    output logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rob_src2_id,
    input  logic                                 rob_src1_hit,
    input  logic                                 rob_src2_hit,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rob_src1_data,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rob_src2_data,

    // Register file write snoop
    input  logic                                 rf_write_en,
    input  logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rf_write_rob_id,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rf_write_data,

    // Issue to the multiplier
    output logic                                 issue_valid,
    output logic [mul_cfg_pkg::DATA_WIDTH-1:0]   issue_ra,
    output logic [mul_cfg_pkg::DATA_WIDTH-1:0]   issue_rb,
    output mul_types_pkg::mul_tag_t              issue_tag
);

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    // Held request and per-source capture state
    logic                  waiting_q;
    mul_request_t          req_held_q;
    logic                  found1_q;
    logic                  found2_q;
    logic [DATA_WIDTH-1:0] data1_q;
    logic [DATA_WIDTH-1:0] data2_q;

    logic                  accept;
    logic                  active;
    mul_request_t          cur_req;
    logic                  snoop1;
    logic                  snoop2;
    logic                  capture1;
    logic                  capture2;
    logic                  ready1;
    logic                  ready2;

    ////////////////////////////////////////
    // Live or held request

    // New requests are ignored while one is waiting
    assign accept  = req_valid & ~waiting_q;
    assign active  = accept | waiting_q;
    assign cur_req = accept ? req_info : req_held_q;

    assign rob_src1_id = cur_req.ticket_src1;
    assign rob_src2_id = cur_req.ticket_src2;

    ////////////////////////////////////////
    // Operand readiness

    always_comb
    begin
        snoop1 = rf_write_en & (rf_write_rob_id == cur_req.ticket_src1);
        snoop2 = rf_write_en & (rf_write_rob_id == cur_req.ticket_src2);

        ready1 = ~cur_req.rob_blocks_src1 | rob_src1_hit | found1_q;
        ready2 = ~cur_req.rob_blocks_src2 | rob_src2_hit | found2_q;

        // Only blocked sources not yet found record anything
        capture1 = active & cur_req.rob_blocks_src1 & ~found1_q & (rob_src1_hit | snoop1);
        capture2 = active & cur_req.rob_blocks_src2 & ~found2_q & (rob_src2_hit | snoop2);

        if (!cur_req.rob_blocks_src1)
            issue_ra = cur_req.ra_data;
        else if (rob_src1_hit)
            issue_ra = rob_src1_data;
        else
            issue_ra = data1_q;

        if (!cur_req.rob_blocks_src2)
            issue_rb = cur_req.rb_data;
        else if (rob_src2_hit)
            issue_rb = rob_src2_data;
        else
            issue_rb = data2_q;
    end

    assign issue_valid = active & ready1 & ready2 & ~flush;
    assign stall       = active & ~(ready1 & ready2) & ~flush;

    assign issue_tag.instr_id = cur_req.instr_id;
    assign issue_tag.rd_addr  = cur_req.rd_addr;
    assign issue_tag.pc       = cur_req.pc;

    ////////////////////////////////////////
    // Wait state

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            waiting_q <= 1'b0;
            found1_q  <= 1'b0;
            found2_q  <= 1'b0;
        end
        else
        begin
            waiting_q <= stall;
            if (issue_valid)
            begin
                found1_q <= 1'b0;
                found2_q <= 1'b0;
            end
            else
            begin
                found1_q <= found1_q | capture1;
                found2_q <= found2_q | capture2;
            end
        end
    end

    // Request and captured operands
    always_ff @(posedge clock)
    begin
        if (accept)
            req_held_q <= req_info;
        // ROB hit wins over a write seen in the same cycle
        if (capture1)
            data1_q <= rob_src1_hit ? rob_src1_data : rf_write_data;
        if (capture2)
            data2_q <= rob_src2_hit ? rob_src2_data : rf_write_data;
    end

endmodule

/* mul_pipeline.sv */
module mul_pipeline
(
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  flush,

    // From the operand collector
    input  logic                                  issue_valid,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]    issue_ra,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]    issue_rb,
    input  mul_types_pkg::mul_tag_t               issue_tag,

    // To the writeback stage
    output logic                                  pipe_valid,
    output logic [mul_cfg_pkg::PRODUCT_WIDTH-1:0] pipe_product,
    output mul_types_pkg::mul_tag_t               pipe_tag
);

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic [PRODUCT_WIDTH-1:0] ra_ext;
    logic [PRODUCT_WIDTH-1:0] rb_ext;
    logic [PRODUCT_WIDTH-1:0] product;

    ////////////////////////////////////////
    // Unsigned full-width product

    assign ra_ext  = {{DATA_WIDTH{1'b0}}, issue_ra};
    assign rb_ext  = {{DATA_WIDTH{1'b0}}, issue_rb};
    assign product = ra_ext * rb_ext;

    ////////////////////////////////////////
    // Retiming stages

    // Product and the valid bit
    delay_line
    #(
        .payload_t (logic [PRODUCT_WIDTH-1:0]),
        .DEPTH     (MUL_STAGES)
    )
    product_stages
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (issue_valid),
        .in_data   (product),
        .out_valid (pipe_valid),
        .out_data  (pipe_product)
    );

    // Tag moves in lockstep so its own valid is redundant
    delay_line
    #(
        .payload_t (mul_tag_t),
        .DEPTH     (MUL_STAGES)
    )
    tag_stages
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (issue_valid),
        .in_data   (issue_tag),
        .out_valid (),
        .out_data  (pipe_tag)
    );

endmodule

/* wb_formatter.sv */
module wb_formatter
(
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  flush,

    // From the last multiplier stage
    input  logic                                  pipe_valid,
    input  logic [mul_cfg_pkg::PRODUCT_WIDTH-1:0] pipe_product,
    input  mul_types_pkg::mul_tag_t               pipe_tag,

    // Writeback request
    output logic                                  wb_valid,
    output mul_types_pkg::wb_request_t            wb_info
);

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    wb_request_t wb_next;

    always_comb
    begin
        wb_next.instr_id = pipe_tag.instr_id;
        wb_next.pc       = pipe_tag.pc;
        wb_next.rd_addr  = pipe_tag.rd_addr;
        wb_next.data     = pipe_product[DATA_WIDTH-1:0];
        // Result does not fit in one register
        wb_next.overflow = |pipe_product[PRODUCT_WIDTH-1:DATA_WIDTH];
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
            wb_valid <= 1'b0;
        else
            wb_valid <= pipe_valid;
    end

    always_ff @(posedge clock)
    begin
        if (pipe_valid)
            wb_info <= wb_next;
    end

endmodule

/* mul_unit.sv */
module mul_unit
(
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 flush,

    // Decode
    input  logic                                 req_valid,
    input  mul_types_pkg::mul_request_t          req_info,
    output logic                                 stall,

    // ROB bypass
    output logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rob_src1_id,
    output logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rob_src2_id,
    input  logic                                 rob_src1_hit,
    input  logic                                 rob_src2_hit,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rob_src1_data,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rob_src2_data,

    // Register file write snoop
    input  logic                                 rf_write_en,
    input  logic [mul_cfg_pkg::ROB_ID_WIDTH-1:0] rf_write_rob_id,
    input  logic [mul_cfg_pkg::DATA_WIDTH-1:0]   rf_write_data,

    // Writeback
    output logic                                 wb_valid,
    output mul_types_pkg::wb_request_t           wb_info
);

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    logic                     issue_valid;
    logic [DATA_WIDTH-1:0]    issue_ra;
    logic [DATA_WIDTH-1:0]    issue_rb;
    mul_tag_t                 issue_tag;

    logic                     pipe_valid;
    logic [PRODUCT_WIDTH-1:0] pipe_product;
    mul_tag_t                 pipe_tag;

    operand_collector collector
    (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (flush),
        .req_valid       (req_valid),
        .req_info        (req_info),
        .stall           (stall),
        .rob_src1_id     (rob_src1_id),
        .rob_src2_id     (rob_src2_id),
        .rob_src1_hit    (rob_src1_hit),
        .rob_src2_hit    (rob_src2_hit),
        .rob_src1_data   (rob_src1_data),
        .rob_src2_data   (rob_src2_data),
        .rf_write_en     (rf_write_en),
        .rf_write_rob_id (rf_write_rob_id),
        .rf_write_data   (rf_write_data),
        .issue_valid     (issue_valid),
        .issue_ra        (issue_ra),
        .issue_rb        (issue_rb),
        .issue_tag       (issue_tag)
    );

    mul_pipeline pipeline
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ra     (issue_ra),
        .issue_rb     (issue_rb),
        .issue_tag    (issue_tag),
        .pipe_valid   (pipe_valid),
        .pipe_product (pipe_product),
        .pipe_tag     (pipe_tag)
    );

    wb_formatter writeback
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .flush        (flush),
        .pipe_valid   (pipe_valid),
        .pipe_product (pipe_product),
        .pipe_tag     (pipe_tag),
        .wb_valid     (wb_valid),
        .wb_info      (wb_info)
    );

endmodule

/* tb_mul_unit.sv */
module tb_mul_unit;

    import mul_cfg_pkg::*;
    import mul_types_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int SEED          = 95870;
    // Longest wait for one writeback
    localparam int WB_WAIT_LIMIT = 16;
    // Worst case of each test in turn, every writeback wait at its limit
    localparam int TEST_CYCLES   = RESET_CYCLES
                                 + 3 * (WB_WAIT_LIMIT + 2)
                                 + (WB_WAIT_LIMIT + 2)
                                 + (WB_WAIT_LIMIT + 4)
                                 + 10
                                 + (WB_WAIT_LIMIT + 14);
    localparam int MARGIN_CYCLES = 50;

    logic                      clock;
    logic                      rst_n;
    logic                      flush;
    logic                      req_valid;
    mul_request_t              req_info;
    logic                      stall;
    logic [ROB_ID_WIDTH-1:0]   rob_src1_id;
    logic [ROB_ID_WIDTH-1:0]   rob_src2_id;
    logic                      rob_src1_hit;
    logic                      rob_src2_hit;
    logic [DATA_WIDTH-1:0]     rob_src1_data;
    logic [DATA_WIDTH-1:0]     rob_src2_data;
    logic                      rf_write_en;
    logic [ROB_ID_WIDTH-1:0]   rf_write_rob_id;
    logic [DATA_WIDTH-1:0]     rf_write_data;
    logic                      wb_valid;
    wb_request_t               wb_info;

    int                        test_errors;
    int                        pass_count;
    int                        fail_count;
    logic [ROB_ID_WIDTH-1:0]   next_id;

    mul_unit UUT
    (
        .clock           (clock),
        .rst_n           (rst_n),
        .flush           (flush),
        .req_valid       (req_valid),
        .req_info        (req_info),
        .stall           (stall),
        .rob_src1_id     (rob_src1_id),
        .rob_src2_id     (rob_src2_id),
        .rob_src1_hit    (rob_src1_hit),
        .rob_src2_hit    (rob_src2_hit),
        .rob_src1_data   (rob_src1_data),
        .rob_src2_data   (rob_src2_data),
        .rf_write_en     (rf_write_en),
        .rf_write_rob_id (rf_write_rob_id),
        .rf_write_data   (rf_write_data),
        .wb_valid        (wb_valid),
        .wb_info         (wb_info)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Watchdog
    initial
    begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run went past %0d cycles without finishing",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers

    // Inputs change 1 unit after the rising edge
    task step;
        begin
            @(posedge clock);
            #1;
        end
    endtask

    task check_value(input string name, input logic [63:0] actual,
                     input logic [63:0] expected);
        begin
            if (actual !== expected)
            begin
                $display("FAIL %s: got %h, expected %h", name, actual, expected);
                test_errors++;
            end
        end
    endtask

    task finish_test(input string name);
        begin
            if (test_errors == 0)
            begin
                $display("%-22s ok", name);
                pass_count++;
            end
            else
            begin
                $display("%-22s %0d errors", name, test_errors);
                fail_count++;
            end
            test_errors = 0;
        end
    endtask

    // ROB answers in the same cycle as the lookup
    task rob_respond(input logic hit1, input logic [DATA_WIDTH-1:0] data1,
                     input logic hit2, input logic [DATA_WIDTH-1:0] data2);
        begin
            rob_src1_hit  = hit1;
            rob_src1_data = data1;
            rob_src2_hit  = hit2;
            rob_src2_data = data2;
        end
    endtask

    function automatic mul_request_t make_request(
        input logic [DATA_WIDTH-1:0] ra, input logic [DATA_WIDTH-1:0] rb,
        input logic blk1, input logic blk2, input logic [ROB_ID_WIDTH-1:0] id);
        mul_request_t r;
        r.ra_data         = ra;
        r.rb_data         = rb;
        r.ticket_src1     = id + 5'd7;
        r.ticket_src2     = id + 5'd13;
        r.rob_blocks_src1 = blk1;
        r.rob_blocks_src2 = blk2;
        r.rd_addr         = id ^ 5'h15;
        r.instr_id        = id;
        r.pc              = 32'h0000_4000 + {id, 2'b00};
        return r;
    endfunction

    // Low half as data, nonzero high half as overflow
    function automatic wb_request_t expected_result(input mul_request_t r,
        input logic [DATA_WIDTH-1:0] ra, input logic [DATA_WIDTH-1:0] rb);
        logic [PRODUCT_WIDTH-1:0] full;
        wb_request_t e;
        // Shift and add over the bits of rb
        full = '0;
        for (int i = 0; i < DATA_WIDTH; i++)
        begin
            if (rb[i])
                full = full + ({{DATA_WIDTH{1'b0}}, ra} << i);
        end
        e.instr_id = r.instr_id;
        e.pc       = r.pc;
        e.rd_addr  = r.rd_addr;
        e.data     = full[DATA_WIDTH-1:0];
        e.overflow = (full[PRODUCT_WIDTH-1:DATA_WIDTH] != '0);
        return e;
    endfunction

    task check_result(input wb_request_t exp);
        begin
            check_value("wb_info.data", wb_info.data, exp.data);
            check_value("wb_info.overflow", wb_info.overflow, exp.overflow);
            check_value("wb_info.instr_id", wb_info.instr_id, exp.instr_id);
            check_value("wb_info.rd_addr", wb_info.rd_addr, exp.rd_addr);
            check_value("wb_info.pc", wb_info.pc, exp.pc);
        end
    endtask

    // Counts edges until wb_valid shows up
    task wait_for_wb(input int start, output int edges);
        begin
            edges = start;
            while (!wb_valid && edges < start + WB_WAIT_LIMIT)
            begin
                step();
                edges++;
            end
            if (!wb_valid)
            begin
                $display("No writeback appeared within %0d cycles", WB_WAIT_LIMIT);
                test_errors++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Tests

    task issue_ready_operands;
        mul_request_t          r;
        logic [DATA_WIDTH-1:0] ra;
        logic [DATA_WIDTH-1:0] rb;
        int                    edges;
        begin
            for (int k = 0; k < 3; k++)
            begin
                ra = $urandom;
                rb = $urandom;
                // Small pair cannot overflow, top bits set always do
                if (k == 1)
                begin
                    ra = ra & 32'h0000_ffff;
                    rb = rb & 32'h0000_ffff;
                end
                else if (k == 2)
                begin
                    ra = ra | 32'h8000_0000;
                    rb = rb | 32'h8000_0000;
                end
                r = make_request(ra, rb, 1'b0, 1'b0, next_id);
                next_id++;
                req_info  = r;
                req_valid = 1'b1;
                #1;
                check_value("stall", stall, 1'b0);
                step();
                req_valid = 1'b0;
                wait_for_wb(1, edges);
                check_value("latency", edges, 4);
                check_result(expected_result(r, ra, rb));
                step();
            end
            finish_test("ready operands");
        end
    endtask

    task bypass_from_rob;
        mul_request_t r;
        int           edges;
        begin
            r = make_request(32'h1111_1111, 32'h2222_2222, 1'b1, 1'b1, next_id);
            next_id++;
            req_info  = r;
            req_valid = 1'b1;
            rob_respond(1'b1, 32'h0001_2345, 1'b1, 32'h0000_0abc);
            #1;
            check_value("stall", stall, 1'b0);
            check_value("rob_src1_id", rob_src1_id, r.ticket_src1);
            check_value("rob_src2_id", rob_src2_id, r.ticket_src2);
            step();
            req_valid = 1'b0;
            rob_respond(1'b0, '0, 1'b0, '0);
            wait_for_wb(1, edges);
            check_value("latency", edges, 4);
            check_result(expected_result(r, 32'h0001_2345, 32'h0000_0abc));
            step();
            finish_test("rob bypass");
        end
    endtask

    task wake_by_snoop;
        mul_request_t r;
        int           edges;
        begin
            r = make_request(32'hdead_beef, 32'h0000_0321, 1'b1, 1'b0, next_id);
            next_id++;
            req_info  = r;
            req_valid = 1'b1;
            #1;
            check_value("stall", stall, 1'b1);
            step();
            req_valid = 1'b0;
            // Write to some other ticket
            rf_write_en     = 1'b1;
            rf_write_rob_id = r.ticket_src1 ^ 5'h01;
            rf_write_data   = 32'h5555_5555;
            #1;
            check_value("stall", stall, 1'b1);
            step();
            rf_write_rob_id = r.ticket_src1;
            rf_write_data   = 32'h0000_7777;
            #1;
            check_value("stall", stall, 1'b1);
            step();
            rf_write_en = 1'b0;
            #1;
            check_value("stall", stall, 1'b0);
            wait_for_wb(0, edges);
            check_value("latency", edges, 4);
            check_result(expected_result(r, 32'h0000_7777, 32'h0000_0321));
            step();
            finish_test("snoop wake");
        end
    endtask

    task stream_back_to_back;
        mul_request_t r;
        wb_request_t  exp_q [5];
        logic         expect_wb;
        begin
            for (int n = 0; n < 10; n++)
            begin
                if (n < 5)
                begin
                    r = make_request($urandom, $urandom, 1'b0, 1'b0, next_id);
                    next_id++;
                    exp_q[n]  = expected_result(r, r.ra_data, r.rb_data);
                    req_info  = r;
                    req_valid = 1'b1;
                end
                else
                    req_valid = 1'b0;
                #1;
                expect_wb = (n >= 4) && (n < 9);
                check_value("stall", stall, 1'b0);
                check_value("wb_valid", wb_valid, expect_wb);
                if (expect_wb)
                    check_result(exp_q[n-4]);
                step();
            end
            finish_test("back to back");
        end
    endtask

    task flush_in_flight;
        mul_request_t r;
        int           edges;
        begin
            // Two ready requests, then one stalled on source 1
            for (int n = 0; n < 3; n++)
            begin
                req_info  = make_request($urandom, $urandom, n == 2, 1'b0, next_id);
                next_id++;
                req_valid = 1'b1;
                #1;
                check_value("stall", stall, n == 2);
                step();
            end
            req_valid = 1'b0;
            flush     = 1'b1;
            #1;
            check_value("stall", stall, 1'b0);
            step();
            flush = 1'b0;
            repeat (8)
            begin
                #1;
                check_value("wb_valid", wb_valid, 1'b0);
                check_value("stall", stall, 1'b0);
                step();
            end
            r = make_request(32'h0badf00d, 32'h0000_0010, 1'b0, 1'b0, next_id);
            next_id++;
            req_info  = r;
            req_valid = 1'b1;
            step();
            req_valid = 1'b0;
            wait_for_wb(1, edges);
            check_value("latency", edges, 4);
            check_result(expected_result(r, r.ra_data, r.rb_data));
            step();
            finish_test("flush");
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial
    begin
        clock           = 1'b0;
        rst_n           = 1'b0;
        flush           = 1'b0;
        req_valid       = 1'b0;
        req_info        = '0;
        rob_src1_hit    = 1'b0;
        rob_src2_hit    = 1'b0;
        rob_src1_data   = '0;
        rob_src2_data   = '0;
        rf_write_en     = 1'b0;
        rf_write_rob_id = '0;
        rf_write_data   = '0;
        test_errors     = 0;
        pass_count      = 0;
        fail_count      = 0;
        next_id         = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
        check_value("stall", stall, 1'b0);
        check_value("wb_valid", wb_valid, 1'b0);
        finish_test("reset state");

        issue_ready_operands();
        bypass_from_rob();
        wake_by_snoop();
        stream_back_to_back();
        flush_in_flight();

        $display("Summary: %0d ok, %0d with errors", pass_count, fail_count);
        if (fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* filelist.f */
mul_cfg_pkg.sv
mul_types_pkg.sv
delay_line.sv
operand_collector.sv
mul_pipeline.sv
wb_formatter.sv
mul_unit.sv
tb_mul_unit.sv
